// File: linear_accel_top.f
rtl/systolic_pkg.sv
rtl/stream_if.sv
rtl/processing_element.sv
rtl/reset_sequencer.sv
rtl/result_formatter.sv
rtl/linear_processing_array.sv
rtl/linear_accel_top.sv
verification/tb_linear_accel.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= linear_accel_top.f
RTL_TOP    ?= linear_accel_top
TB_TOP     ?= tb_linear_accel
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= PASS: all tests
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_linear_accel.sv
`timescale 1ns/1ps

module tb_linear_accel;

  localparam int dc = systolic_pkg::data_channels;
  localparam int rc = systolic_pkg::rslt_channels;
  localparam int n0 = systolic_pkg::op0_lanes;
  localparam int n1 = systolic_pkg::op1_lanes;
  localparam int nr = systolic_pkg::rslt_lanes;
  localparam int w0 = systolic_pkg::op0_width;
  localparam int w1 = systolic_pkg::op1_width;
  localparam int rw = systolic_pkg::rslt_width;
  localparam int timeout_cycles = 200;
  localparam int hist_depth = 64;

  logic clk = 1'b0;
  logic INTERNAL_RESET;
  logic [n0*w0-1:0] s_op0_data;
  logic [n0-1:0] s_op0_valid;
  logic [n0-1:0] s_op0_ready;
  logic [n0-1:0] s_op0_last;
  logic [n1*w1-1:0] s_op1_data;
  logic [n1-1:0] s_op1_valid;
  logic [n1-1:0] s_op1_ready;
  logic [n1-1:0] s_op1_last;
  logic [nr*rw-1:0] m_data;
  logic [nr-1:0] m_valid;
  logic [nr-1:0] m_ready;
  logic [nr-1:0] m_last;
  logic err_unaligned;
  logic core_rst;

  logic stall_mode;
  int cyc;
  string test_name;
  int error_count = 0;
  int check_count = 0;

  // Reference model state filled from port transfers
  systolic_pkg::op0_t op0_hist [n0][hist_depth];
  logic op0_last_hist [n0][hist_depth];
  systolic_pkg::op1_t op1_hist [n1][hist_depth];
  int op0_cnt [n0];
  int op1_cnt [n1];
  int out_cnt [nr];
  systolic_pkg::rslt_t exp_data [nr];
  logic exp_last [nr];
  logic exp_ok [nr];
  logic fresh_input = 1'b0;
  int rst_run;

  systolic_pkg::op0_t x_in [n0];
  systolic_pkg::op1_t w_in [n1];

  linear_accel_top UUT (
    .clk            (clk),
    .INTERNAL_RESET (INTERNAL_RESET),
    .s_op0_data     (s_op0_data),
    .s_op0_valid    (s_op0_valid),
    .s_op0_ready    (s_op0_ready),
    .s_op0_last     (s_op0_last),
    .s_op1_data     (s_op1_data),
    .s_op1_valid    (s_op1_valid),
    .s_op1_ready    (s_op1_ready),
    .s_op1_last     (s_op1_last),
    .m_data         (m_data),
    .m_valid        (m_valid),
    .m_ready        (m_ready),
    .m_last         (m_last),
    .err_unaligned  (err_unaligned),
    .core_rst       (core_rst)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    #2;
    cyc = cyc + 1;
  end

  // Lanes 0 and 3 stall in a fixed pattern
  assign m_ready = stall_mode ? {cyc[1] & cyc[2], 1'b1, 1'b1, cyc[0]} : '1;

  // Results the captured inputs allow on one output lane
  function automatic int avail_count(int lane);
    int b;
    int i;
    int n;
    b = lane / rc;
    i = lane % rc;
    n = hist_depth;
    for (int j = 0; j < dc; j++) begin
      n = (op0_cnt[b*dc+j] < n) ? op0_cnt[b*dc+j] : n;
      n = (op1_cnt[j*rc+i] < n) ? op1_cnt[j*rc+i] : n;
    end
    return n;
  endfunction

  // Sum over rows, then floor to the result format
  function automatic systolic_pkg::rslt_t dot_result(int lane, int n);
    longint acc;
    int b;
    int i;
    b = lane / rc;
    i = lane % rc;
    acc = 0;
    for (int j = 0; j < dc; j++) begin
      acc += longint'(op0_hist[b*dc+j][n]) * longint'(op1_hist[j*rc+i][n]);
    end
    return systolic_pkg::rslt_t'(acc >>> systolic_pkg::rslt_lsb);
  endfunction

  function automatic logic all_drained();
    for (int k = 0; k < nr; k++) begin
      if (avail_count(k) != out_cnt[k]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Transfers seen here complete on the next rising edge
  always @(negedge clk) begin
    if (core_rst) begin
      for (int k = 0; k < n0; k++) begin
        op0_cnt[k] = 0;
      end
      for (int k = 0; k < n1; k++) begin
        op1_cnt[k] = 0;
      end
      for (int k = 0; k < nr; k++) begin
        out_cnt[k] = 0;
      end
      fresh_input = 1'b0;
    end else begin
      for (int k = 0; k < n0; k++) begin
        if (s_op0_valid[k] && s_op0_ready[k]) begin
          op0_hist[k][op0_cnt[k]] = s_op0_data[k*w0 +: w0];
          op0_last_hist[k][op0_cnt[k]] = s_op0_last[k];
          op0_cnt[k]++;
          fresh_input = 1'b1;
        end
      end
      for (int k = 0; k < n1; k++) begin
        if (s_op1_valid[k] && s_op1_ready[k]) begin
          op1_hist[k][op1_cnt[k]] = s_op1_data[k*w1 +: w1];
          op1_cnt[k]++;
          fresh_input = 1'b1;
        end
      end
      for (int k = 0; k < nr; k++) begin
        exp_ok[k] = avail_count(k) > out_cnt[k];
        exp_data[k] = dot_result(k, out_cnt[k]);
        // Last comes from the bottom row of the column
        exp_last[k] = op0_last_hist[(k/rc)*dc+dc-1][out_cnt[k]];
        if (m_valid[k] && m_ready[k]) begin
          out_cnt[k]++;
          check_count++;
        end
      end
    end
    rst_run = core_rst ? rst_run + 1 : 0;
  end

  for (genvar k = 0; k < nr; k++) begin : g_check
    a_result_value: assert property (@(posedge clk) disable iff (core_rst)
      m_valid[k] && m_ready[k] && exp_ok[k]
      |-> m_data[k*rw +: rw] == exp_data[k] && m_last[k] == exp_last[k])
      else begin
        error_count++;
        $display("Mismatch %s lane %0d: expected %h last %b, actual %h last %b", test_name, k,
                 exp_data[k], exp_last[k], $sampled(m_data[k*rw +: rw]), $sampled(m_last[k]));
      end

    a_result_known: assert property (@(posedge clk) disable iff (core_rst)
      m_valid[k] && m_ready[k] |-> exp_ok[k])
      else begin
        error_count++;
        $display("Error in %s: lane %0d delivered a result with no matching inputs", test_name, k);
      end

    a_result_hold: assert property (@(posedge clk) disable iff (core_rst)
      m_valid[k] && !m_ready[k]
      |=> m_valid[k] && $stable(m_data[k*rw +: rw]) && $stable(m_last[k]))
      else begin
        error_count++;
        $display("Error in %s: lane %0d result changed while stalled", test_name, k);
      end
  end

  a_error_resets: assert property (@(posedge clk) $rose(err_unaligned) |=> core_rst)
    else begin
      error_count++;
      $display("Error: core reset did not follow the unaligned flag by one cycle");
    end

  a_reset_length: assert property (@(posedge clk)
    $fell(core_rst) |-> $past(rst_run) >= systolic_pkg::reset_stages + 1)
    else begin
      error_count++;
      $display("Error: core reset lasted only %0d cycles", $past(rst_run));
    end

  a_ready_low: assert property (@(posedge clk) core_rst |-> s_op0_ready == '0 && s_op1_ready == '0)
    else begin
      error_count++;
      $display("Error in %s: operand ready high during core reset", test_name);
    end

  // Formatters and the error flag clear one cycle into the reset
  a_quiet_in_reset: assert property (@(posedge clk)
    core_rst && $past(core_rst) |-> m_valid == '0 && !err_unaligned)
    else begin
      error_count++;
      $display("Error in %s: output valid or error flag high during core reset", test_name);
    end

  a_no_early_result: assert property (@(posedge clk) !core_rst && !fresh_input |-> m_valid == '0)
    else begin
      error_count++;
      $display("Error in %s: result valid after reset before any input", test_name);
    end

  task automatic fill_vector(input int v);
    for (int k = 0; k < n0; k++) begin
      x_in[k] = systolic_pkg::op0_t'(((v * 5 + k * 3) % 11) * 1200 - 6000);
    end
    for (int k = 0; k < n1; k++) begin
      w_in[k] = systolic_pkg::op1_t'(((v * 7 + k * 5) % 13) * 900 - 5400);
    end
  endtask

  // Offers one vector on every operand lane
  // The weight lane named by bad_lane gets the opposite last flag
  task automatic send_vector(input logic last_flag, input int bad_lane);
    logic [n0-1:0] pend0;
    logic [n1-1:0] pend1;
    int waited;
    pend0 = '1;
    pend1 = '1;
    waited = 0;
    for (int k = 0; k < n0; k++) begin
      s_op0_data[k*w0 +: w0] = x_in[k];
      s_op0_last[k] = last_flag;
    end
    for (int k = 0; k < n1; k++) begin
      s_op1_data[k*w1 +: w1] = w_in[k];
      s_op1_last[k] = last_flag ^ (k == bad_lane);
    end
    s_op0_valid = pend0;
    s_op1_valid = pend1;
    while ((pend0 != '0 || pend1 != '0) && waited < timeout_cycles) begin
      @(negedge clk);
      pend0 = pend0 & ~s_op0_ready;
      pend1 = pend1 & ~s_op1_ready;
      @(posedge clk);
      #2;
      s_op0_valid = pend0;
      s_op1_valid = pend1;
      waited++;
    end
    if (pend0 != '0 || pend1 != '0) begin
      error_count++;
      $display("Timeout in %s: operand lanes not accepted after %0d cycles", test_name, waited);
      s_op0_valid = '0;
      s_op1_valid = '0;
    end
  endtask

  task automatic run_vectors(input int count, input int first, input int last_every);
    for (int v = 0; v < count; v++) begin
      fill_vector(first + v);
      send_vector((v % last_every) == last_every - 1, -1);
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (!all_drained() && waited < timeout_cycles) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!all_drained()) begin
      error_count++;
      $display("Timeout in %s: results still missing after %0d cycles", test_name, waited);
    end
  endtask

  // Selector 0 watches core_rst and 1 watches err_unaligned
  task automatic wait_for_level(input int which, input logic level, input string what);
    int waited;
    waited = 0;
    while (((which == 0) ? core_rst : err_unaligned) !== level && waited < timeout_cycles) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (((which == 0) ? core_rst : err_unaligned) !== level) begin
      error_count++;
      $display("Timeout in %s: no %s after %0d cycles", test_name, what, waited);
    end
  endtask

  initial begin
    INTERNAL_RESET = 1'b1;
    s_op0_data = '0;
    s_op0_valid = '0;
    s_op0_last = '0;
    s_op1_data = '0;
    s_op1_valid = '0;
    s_op1_last = '0;
    stall_mode = 1'b0;
    test_name = "reset";
    repeat (2) @(posedge clk);
    #2;
    // Operands offered while the core is in reset must not be taken
    s_op0_valid = '1;
    s_op1_valid = '1;
    repeat (14) @(posedge clk);
    #2;
    INTERNAL_RESET = 1'b0;
    s_op0_valid = '0;
    s_op1_valid = '0;
    wait_for_level(0, 1'b0, "core reset release");
    repeat (6) @(posedge clk);
    #2;

    test_name = "products";
    run_vectors(12, 0, 4);
    wait_drained();

    test_name = "backpressure";
    stall_mode = 1'b1;
    run_vectors(16, 12, 4);
    wait_drained();
    stall_mode = 1'b0;

    test_name = "last";
    run_vectors(6, 28, 2);
    wait_drained();

    test_name = "unaligned";
    fill_vector(40);
    send_vector(1'b1, 1);
    wait_for_level(1, 1'b1, "unaligned flag");
    wait_for_level(0, 1'b1, "core reset");
    wait_for_level(0, 1'b0, "core reset release");
    repeat (6) @(posedge clk);
    #2;

    test_name = "after_reset";
    run_vectors(6, 41, 3);
    wait_drained();

    $display("Results checked: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: rtl/linear_accel_top.sv
`timescale 1ns/1ps

module linear_accel_top (
  input  logic clk,
  input  logic INTERNAL_RESET,

  input  logic [systolic_pkg::op0_lanes*systolic_pkg::op0_width-1:0]   s_op0_data,
  input  logic [systolic_pkg::op0_lanes-1:0]                           s_op0_valid,
  output logic [systolic_pkg::op0_lanes-1:0]                           s_op0_ready,
  input  logic [systolic_pkg::op0_lanes-1:0]                           s_op0_last,

  input  logic [systolic_pkg::op1_lanes*systolic_pkg::op1_width-1:0]   s_op1_data,
  input  logic [systolic_pkg::op1_lanes-1:0]                           s_op1_valid,
  output logic [systolic_pkg::op1_lanes-1:0]                           s_op1_ready,
  input  logic [systolic_pkg::op1_lanes-1:0]                           s_op1_last,

  output logic [systolic_pkg::rslt_lanes*systolic_pkg::rslt_width-1:0] m_data,
  output logic [systolic_pkg::rslt_lanes-1:0]                          m_valid,
  input  logic [systolic_pkg::rslt_lanes-1:0]                          m_ready,
  output logic [systolic_pkg::rslt_lanes-1:0]                          m_last,

  output logic err_unaligned,
  output logic core_rst
);

  stream_if #(.payload_t(systolic_pkg::op0_t))  op0_bus  [systolic_pkg::op0_lanes]  (.clk(clk));
  stream_if #(.payload_t(systolic_pkg::op1_t))  op1_bus  [systolic_pkg::op1_lanes]  (.clk(clk));
  stream_if #(.payload_t(systolic_pkg::psum_t)) psum_bus [systolic_pkg::rslt_lanes] (.clk(clk));

  // Unpack the flat operand ports into lanes
  for (genvar k = 0; k < systolic_pkg::op0_lanes; k++) begin : g_op0_lane
    assign op0_bus[k].data  = s_op0_data[k*systolic_pkg::op0_width +: systolic_pkg::op0_width];
    assign op0_bus[k].valid = s_op0_valid[k];
    assign op0_bus[k].last  = s_op0_last[k];
    assign s_op0_ready[k]   = op0_bus[k].ready;
  end

  for (genvar k = 0; k < systolic_pkg::op1_lanes; k++) begin : g_op1_lane
    assign op1_bus[k].data  = s_op1_data[k*systolic_pkg::op1_width +: systolic_pkg::op1_width];
    assign op1_bus[k].valid = s_op1_valid[k];
    assign op1_bus[k].last  = s_op1_last[k];
    assign s_op1_ready[k]   = op1_bus[k].ready;
  end

  reset_sequencer u_reset_seq (
    .clk            (clk),
    .INTERNAL_RESET (INTERNAL_RESET),
    .err_unaligned  (err_unaligned),
    .core_rst       (core_rst)
  );

  linear_processing_array u_array (
    .clk           (clk),
    .rst           (core_rst),
    .op0           (op0_bus),
    .op1           (op1_bus),
    .psum          (psum_bus),
    .err_unaligned (err_unaligned)
  );

  // One formatter per batch and column
  for (genvar k = 0; k < systolic_pkg::rslt_lanes; k++) begin : g_rslt_lane
    result_formatter u_fmt (
      .clk     (clk),
      .rst     (core_rst),
      .psum    (psum_bus[k]),
      .m_data  (m_data[k*systolic_pkg::rslt_width +: systolic_pkg::rslt_width]),
      .m_valid (m_valid[k]),
      .m_ready (m_ready[k]),
      .m_last  (m_last[k])
    );
  end

endmodule

// File: rtl/linear_processing_array.sv
`timescale 1ns/1ps

module linear_processing_array (
  input  logic     clk,
  input  logic     rst,
  stream_if.sink   op0 [systolic_pkg::op0_lanes],
  stream_if.sink   op1 [systolic_pkg::op1_lanes],
  stream_if.source psum [systolic_pkg::rslt_lanes],
  output logic     err_unaligned
);

  // Horizontal data links, one extra node per row for the right edge
  stream_if #(.payload_t(systolic_pkg::op0_t)) h_bus [
    systolic_pkg::batch_size * systolic_pkg::data_channels * (systolic_pkg::rslt_channels + 1)
  ] (.clk(clk));

  // Weight links between batch planes, one extra plane below the array
  stream_if #(.payload_t(systolic_pkg::op1_t)) v_bus [
    (systolic_pkg::batch_size + 1) * systolic_pkg::data_channels * systolic_pkg::rslt_channels
  ] (.clk(clk));

  // Partial sum links down each column, one extra node above row 0
  stream_if #(.payload_t(systolic_pkg::psum_t)) d_bus [
    systolic_pkg::batch_size * (systolic_pkg::data_channels + 1) * systolic_pkg::rslt_channels
  ] (.clk(clk));

  logic [systolic_pkg::batch_size*systolic_pkg::data_channels*systolic_pkg::rslt_channels-1:0]
    pe_err;

  for (genvar b = 0; b < systolic_pkg::batch_size; b++) begin : g_batch
    for (genvar j = 0; j < systolic_pkg::data_channels; j++) begin : g_row
      for (genvar i = 0; i < systolic_pkg::rslt_channels; i++) begin : g_col
        localparam int uid    = (b * systolic_pkg::data_channels + j)
                                * systolic_pkg::rslt_channels + i;
        localparam int node_l = (b * systolic_pkg::data_channels + j)
                                * (systolic_pkg::rslt_channels + 1) + i;
        localparam int node_t = uid;
        localparam int node_b = uid + systolic_pkg::data_channels * systolic_pkg::rslt_channels;
        localparam int node_u = (b * (systolic_pkg::data_channels + 1) + j)
                                * systolic_pkg::rslt_channels + i;
        localparam int node_d = node_u + systolic_pkg::rslt_channels;

        processing_element #(
          .first_row (j == 0)
        ) u_pe (
          .clk           (clk),
          .rst           (rst),
          .left          (h_bus[node_l]),
          .right         (h_bus[node_l+1]),
          .top           (v_bus[node_t]),
          .bottom        (v_bus[node_b]),
          .up            (d_bus[node_u]),
          .down          (d_bus[node_d]),
          .err_unaligned (pe_err[uid])
        );

        // Operand 0 enters at the left edge
        if (i == 0) begin : g_left_edge
          assign h_bus[node_l].data  = op0[b*systolic_pkg::data_channels+j].data;
          assign h_bus[node_l].valid = op0[b*systolic_pkg::data_channels+j].valid;
          assign h_bus[node_l].last  = op0[b*systolic_pkg::data_channels+j].last;
          assign op0[b*systolic_pkg::data_channels+j].ready = h_bus[node_l].ready;
        end

        // Data leaving the right edge is dropped
        if (i == systolic_pkg::rslt_channels - 1) begin : g_right_edge
          assign h_bus[node_l+1].ready = 1'b1;
        end

        // Weights enter at the first batch plane
        if (b == 0) begin : g_top_edge
          assign v_bus[node_t].data  = op1[uid].data;
          assign v_bus[node_t].valid = op1[uid].valid;
          assign v_bus[node_t].last  = op1[uid].last;
          assign op1[uid].ready      = v_bus[node_t].ready;
        end

        if (b == systolic_pkg::batch_size - 1) begin : g_bottom_edge
          assign v_bus[node_b].ready = 1'b1;
        end

        // Nothing feeds the top of a column
        if (j == 0) begin : g_up_edge
          assign d_bus[node_u].data  = '0;
          assign d_bus[node_u].valid = 1'b0;
          assign d_bus[node_u].last  = 1'b0;
        end

        // Finished column sums go out per batch and column
        if (j == systolic_pkg::data_channels - 1) begin : g_down_edge
          assign psum[b*systolic_pkg::rslt_channels+i].data  = d_bus[node_d].data;
          assign psum[b*systolic_pkg::rslt_channels+i].valid = d_bus[node_d].valid;
          assign psum[b*systolic_pkg::rslt_channels+i].last  = d_bus[node_d].last;
          assign d_bus[node_d].ready = psum[b*systolic_pkg::rslt_channels+i].ready;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      err_unaligned <= 1'b0;
    end else begin
      err_unaligned <= |pe_err;
    end
  end

endmodule

// File: rtl/result_formatter.sv
`timescale 1ns/1ps

module result_formatter (
  input  logic                clk,
  input  logic                rst,
  stream_if.sink              psum,
  output systolic_pkg::rslt_t m_data,
  output logic                m_valid,
  input  logic                m_ready,
  output logic                m_last
);

  logic take;

  // One-entry buffer, refills in the cycle it drains
  assign psum.ready = ~m_valid | m_ready;
  assign take       = psum.valid & psum.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid <= 1'b0;
    end else if (take) begin
      m_valid <= 1'b1;
    end else if (m_ready) begin
      m_valid <= 1'b0;
    end
  end

  // Dropping the low bits rounds toward minus infinity
  always_ff @(posedge clk) begin
    if (take) begin
      m_data <= psum.data[systolic_pkg::rslt_lsb +: systolic_pkg::rslt_width];
      m_last <= psum.last;
    end
  end

  a_result_hold: assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last))
    else $error("result changed or dropped under back-pressure");

endmodule

// File: rtl/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer (
  input  logic clk,
  input  logic INTERNAL_RESET,
  input  logic err_unaligned,
  output logic core_rst
);

  logic rst_req;
  logic [systolic_pkg::reset_stages-1:0] rst_pipe;

  // External reset or a detected misalignment both restart the core
  assign rst_req = INTERNAL_RESET | err_unaligned;

  always_ff @(posedge clk) begin
    rst_pipe <= {rst_pipe[systolic_pkg::reset_stages-2:0], rst_req};
    // Stretch so that even a one-cycle error gives a full reset
    core_rst <= rst_req | (|rst_pipe);
  end

endmodule

// File: rtl/processing_element.sv
`timescale 1ns/1ps

module processing_element #(
  parameter bit first_row = 1'b0
) (
  input  logic     clk,
  input  logic     rst,
  stream_if.sink   left,
  stream_if.source right,
  stream_if.sink   top,
  stream_if.source bottom,
  stream_if.sink   up,
  stream_if.source down,
  output logic     err_unaligned
);

  logic signed [systolic_pkg::op0_width+systolic_pkg::op1_width-1:0] product;
  systolic_pkg::psum_t up_sum;
  logic up_ok;
  logic in_ok;
  logic out_free;
  logic fire;

  // Full-precision signed product
  assign product = left.data * top.data;

  if (first_row) begin : g_top_row
    // Chain starts here, nothing to add
    assign up_sum   = '0;
    assign up_ok    = 1'b1;
    assign up.ready = 1'b0;

    // The array must leave the unused up stream idle
    a_up_idle: assert property (@(posedge clk) disable iff (rst) !up.valid)
      else $error("partial sum offered to a first-row PE");
  end else begin : g_inner_row
    assign up_sum   = up.data;
    assign up_ok    = up.valid;
    assign up.ready = fire;
  end

  // Join of all inputs
  assign in_ok = left.valid & top.valid & up_ok;

  // Each output register is empty or drains this cycle
  assign out_free = (~right.valid  | right.ready)
                  & (~bottom.valid | bottom.ready)
                  & (~down.valid   | down.ready);

  // No transfers accepted while the core is held in reset
  assign fire = in_ok & out_free & ~rst;

  assign left.ready = fire;
  assign top.ready  = fire;

  // Output valids and the error flag
  always_ff @(posedge clk) begin
    if (rst) begin
      right.valid   <= 1'b0;
      bottom.valid  <= 1'b0;
      down.valid    <= 1'b0;
      err_unaligned <= 1'b0;
    end else begin
      if (fire) begin
        right.valid  <= 1'b1;
        bottom.valid <= 1'b1;
        down.valid   <= 1'b1;
      end else begin
        if (right.ready) begin
          right.valid <= 1'b0;
        end
        if (bottom.ready) begin
          bottom.valid <= 1'b0;
        end
        if (down.ready) begin
          down.valid <= 1'b0;
        end
      end
      // Left and top must close their vectors together
      err_unaligned <= fire & (left.last ^ top.last);
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (fire) begin
      right.data  <= left.data;
      right.last  <= left.last;
      bottom.data <= top.data;
      bottom.last <= top.last;
      down.data   <= up_sum + systolic_pkg::psum_t'(product);
      down.last   <= left.last;
    end
  end

  // A stalled partial sum must not change before it is taken
  a_down_hold: assert property (@(posedge clk) disable iff (rst)
    down.valid && !down.ready |=> down.valid && $stable(down.data) && $stable(down.last))
    else $error("partial sum changed while stalled");

endmodule

// File: rtl/stream_if.sv
`timescale 1ns/1ps

// Valid/ready stream with a last flag
interface stream_if #(
  parameter type payload_t = logic
) (
  input logic clk
);

  payload_t data;
  logic     valid;
  logic     ready;
  logic     last;

  // Producer side
  modport source (
    input  clk,
    input  ready,
    output data,
    output valid,
    output last
  );

  // Consumer side
  modport sink (
    input  clk,
    input  data,
    input  valid,
    input  last,
    output ready
  );

endinterface

// File: rtl/systolic_pkg.sv
package systolic_pkg;

  // Array geometry
  // Rows carry the terms of one dot product, columns the results of one batch
  localparam int data_channels = 2;
  localparam int rslt_channels = 2;
  localparam int batch_size    = 2;

  // Stream lane counts at the top level
  localparam int op0_lanes  = batch_size * data_channels;
  localparam int op1_lanes  = data_channels * rslt_channels;
  localparam int rslt_lanes = batch_size * rslt_channels;

  // Operand formats, all signed fixed point
  localparam int op0_width = 16;
  localparam int op0_frac  = 12;
  localparam int op1_width = 16;
  localparam int op1_frac  = 12;

  // Result format
  localparam int rslt_width = 16;
  localparam int rslt_frac  = 12;

  // Accumulator is wide enough for any sum of full products
  localparam int psum_width = 48;

  // First accumulator bit that lands in the result word
  localparam int rslt_lsb = op0_frac + op1_frac - rslt_frac;

  // Depth of the core reset pipeline
  localparam int reset_stages = 3;

  // Payload words
  typedef logic signed [op0_width-1:0]  op0_t;
  typedef logic signed [op1_width-1:0]  op1_t;
  typedef logic signed [psum_width-1:0] psum_t;
  typedef logic signed [rslt_width-1:0] rslt_t;

endpackage
